/* build.f */
src/soc_periph_pkg.sv
src/event_fifo.sv
src/apb_periph_decode.sv
src/apb_gpio.sv
src/apb_timer.sv
src/soc_event_gen.sv
src/soc_periph_top.sv
tb/tb_soc_periph.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --Wno-fatal -f build.f \
  --top-module tb_soc_periph --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulator returned an error"
  exit 1
fi

if echo "$out" | grep -q "^Simulation passed$"; then
  exit 0
fi
exit 1

/* src/apb_gpio.sv */
//////////////////////////////
// gpio with two-flop input sync
// rising-edge events, one cycle per pulse
// GPIO_IN is read only, writes to it are ignored
//////////////////////////////

`timescale 1ns/100ps

module apb_gpio (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  input  soc_periph_pkg::gpio_t    gpio_in_i,
  output soc_periph_pkg::gpio_t    gpio_out_o,
  output soc_periph_pkg::gpio_t    gpio_oe_o,
  output soc_periph_pkg::gpio_t    gpio_evt_o
);

  logic [3:0]            reg_ofs;
  logic                  wr_en;
  soc_periph_pkg::gpio_t dir_q;
  soc_periph_pkg::gpio_t out_q;
  soc_periph_pkg::gpio_t int_en_q;
  soc_periph_pkg::gpio_t sync1_q;
  soc_periph_pkg::gpio_t sync2_q;
  soc_periph_pkg::gpio_t prev_q;
  soc_periph_pkg::gpio_t evt_q;

  assign reg_ofs = apb_req_i.paddr[soc_periph_pkg::REG_OFS_LSB +: 4];

  // access phase, errored offsets never write
  assign wr_en = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite & ~apb_rsp_o.pslverr;

  //////////////////////////////
  // register file
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      int_en_q <= '0;
    end else if (wr_en) begin
      case (reg_ofs)
        soc_periph_pkg::GPIO_DIR:    dir_q    <= apb_req_i.pwdata[soc_periph_pkg::N_GPIO-1:0];
        soc_periph_pkg::GPIO_OUT:    out_q    <= apb_req_i.pwdata[soc_periph_pkg::N_GPIO-1:0];
        soc_periph_pkg::GPIO_INT_EN: int_en_q <= apb_req_i.pwdata[soc_periph_pkg::N_GPIO-1:0];
        default: ;
      endcase
    end
  end

  // read mux, zero extended
  always_comb begin
    apb_rsp_o.prdata  = '0;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b0;
    case (reg_ofs)
      soc_periph_pkg::GPIO_DIR:    apb_rsp_o.prdata = soc_periph_pkg::apb_data_t'(dir_q);
      soc_periph_pkg::GPIO_OUT:    apb_rsp_o.prdata = soc_periph_pkg::apb_data_t'(out_q);
      soc_periph_pkg::GPIO_IN:     apb_rsp_o.prdata = soc_periph_pkg::apb_data_t'(sync2_q);
      soc_periph_pkg::GPIO_INT_EN: apb_rsp_o.prdata = soc_periph_pkg::apb_data_t'(int_en_q);
      default:                     apb_rsp_o.pslverr = 1'b1;
    endcase
  end

  //////////////////////////////
  // pad sync and edge events
  //////////////////////////////
  // prev_q cleared too, so no edge fires out of reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      evt_q   <= '0;
    end else begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      // pulse lands one cycle after the synced edge
      evt_q   <= sync2_q & ~prev_q & int_en_q;
    end
  end

  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;
  assign gpio_evt_o = evt_q;

endmodule

/* src/apb_periph_decode.sv */
//////////////////////////////
// apb slave select, purely combinational
// slave code 3 answers with pslverr
//////////////////////////////

`timescale 1ns/100ps

module apb_periph_decode (
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_req_t gpio_req_o,
  output soc_periph_pkg::apb_req_t tmr_req_o,
  output soc_periph_pkg::apb_req_t evt_req_o,
  input  soc_periph_pkg::apb_rsp_t gpio_rsp_i,
  input  soc_periph_pkg::apb_rsp_t tmr_rsp_i,
  input  soc_periph_pkg::apb_rsp_t evt_rsp_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o
);

  logic [1:0] slv_sel;

  assign slv_sel = apb_req_i.paddr[soc_periph_pkg::SLV_SEL_LSB +: 2];

  // fan out, only the addressed slave keeps psel
  always_comb begin
    gpio_req_o      = apb_req_i;
    tmr_req_o       = apb_req_i;
    evt_req_o       = apb_req_i;
    gpio_req_o.psel = apb_req_i.psel & (slv_sel == soc_periph_pkg::SLV_GPIO);
    tmr_req_o.psel  = apb_req_i.psel & (slv_sel == soc_periph_pkg::SLV_TIMER);
    evt_req_o.psel  = apb_req_i.psel & (slv_sel == soc_periph_pkg::SLV_EVT);
  end

  // response mux back to the master
  always_comb begin
    case (slv_sel)
      soc_periph_pkg::SLV_GPIO:  apb_rsp_o = gpio_rsp_i;
      soc_periph_pkg::SLV_TIMER: apb_rsp_o = tmr_rsp_i;
      soc_periph_pkg::SLV_EVT:   apb_rsp_o = evt_rsp_i;
      default: begin
        // unmapped hole, no slave behind it
        apb_rsp_o.prdata  = '0;
        apb_rsp_o.pready  = 1'b1;
        apb_rsp_o.pslverr = 1'b1;
      end
    endcase
  end

endmodule

/* src/apb_timer.sv */
//////////////////////////////
// counts rising edges of slow_clk_i
// slow clock must stay well below clk_i/2
// a TMR_CNT write wins over a same-cycle increment
//////////////////////////////

`timescale 1ns/100ps

module apb_timer (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     slow_clk_i,
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  output logic                     tmr_evt_o
);

  logic [3:0]                reg_ofs;
  logic                      wr_en;
  logic [2:0]                slow_q;
  logic                      slow_rise;
  logic                      cnt_inc;
  logic                      cfg_en_q;
  soc_periph_pkg::apb_data_t cnt_q;
  soc_periph_pkg::apb_data_t cmp_q;
  logic                      evt_q;

  assign reg_ofs = apb_req_i.paddr[soc_periph_pkg::REG_OFS_LSB +: 4];
  assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite & ~apb_rsp_o.pslverr;

  // two sync flops plus one for edge detect
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      slow_q <= '0;
    end else begin
      slow_q <= {slow_q[1:0], slow_clk_i};
    end
  end

  assign slow_rise = slow_q[1] & ~slow_q[2];
  assign cnt_inc   = cfg_en_q & slow_rise;

  //////////////////////////////
  // counter and compare
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_en_q <= 1'b0;
      cnt_q    <= '0;
      cmp_q    <= '0;
      evt_q    <= 1'b0;
    end else begin
      evt_q <= cnt_inc & (cnt_q == cmp_q);
      if (wr_en && reg_ofs == soc_periph_pkg::TMR_CFG) cfg_en_q <= apb_req_i.pwdata[0];
      if (wr_en && reg_ofs == soc_periph_pkg::TMR_CMP) cmp_q <= apb_req_i.pwdata;
      if (wr_en && reg_ofs == soc_periph_pkg::TMR_CNT) begin
        cnt_q <= apb_req_i.pwdata;
      end else if (cnt_inc) begin
        // wrap on match
        cnt_q <= (cnt_q == cmp_q) ? '0 : cnt_q + 1'b1;
      end
    end
  end

  always_comb begin
    apb_rsp_o.prdata  = '0;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b0;
    case (reg_ofs)
      soc_periph_pkg::TMR_CFG: apb_rsp_o.prdata = soc_periph_pkg::apb_data_t'(cfg_en_q);
      soc_periph_pkg::TMR_CNT: apb_rsp_o.prdata = cnt_q;
      soc_periph_pkg::TMR_CMP: apb_rsp_o.prdata = cmp_q;
      default:                 apb_rsp_o.pslverr = 1'b1;
    endcase
  end

  assign tmr_evt_o = evt_q;

endmodule

/* src/event_fifo.sv */
//////////////////////////////
// small id queue, head shown as valid/ready
// caller must not push while full_o is high
//////////////////////////////

`timescale 1ns/100ps

module event_fifo (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     push_i,
  input  soc_periph_pkg::evt_id_t  push_id_i,
  output logic                     full_o,
  output soc_periph_pkg::evt_msg_t evt_o,
  input  logic                     ready_i
);

  soc_periph_pkg::evt_id_t                mem_q [soc_periph_pkg::EVT_FIFO_DEPTH];
  logic [soc_periph_pkg::EVT_PTR_W-1:0]   wr_ptr_q;
  logic [soc_periph_pkg::EVT_PTR_W-1:0]   rd_ptr_q;
  logic [soc_periph_pkg::EVT_PTR_W:0]     cnt_q;
  logic                                   do_push;
  logic                                   do_pop;

  assign full_o  = cnt_q == (soc_periph_pkg::EVT_PTR_W + 1)'(soc_periph_pkg::EVT_FIFO_DEPTH);
  assign do_push = push_i & ~full_o;
  assign do_pop  = evt_o.valid & ready_i;

  // head of queue
  assign evt_o.valid = cnt_q != '0;
  assign evt_o.id    = mem_q[rd_ptr_q];

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= push_id_i;
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      // push and pop together leave the count alone
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

/* src/soc_event_gen.sv */
//////////////////////////////
// routes events by mask to fc and cluster
// index 0 is fc, index 1 is cluster
// lowest pending id goes first
//////////////////////////////

`timescale 1ns/100ps

module soc_event_gen (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  input  soc_periph_pkg::gpio_t    gpio_evt_i,
  input  logic                     tmr_evt_i,
  output soc_periph_pkg::evt_msg_t fc_event_o,
  output soc_periph_pkg::evt_msg_t cl_event_o,
  input  logic                     fc_event_ready_i,
  input  logic                     cl_event_ready_i
);

  logic [3:0]                            reg_ofs;
  logic                                  wr_en;
  logic [soc_periph_pkg::N_SW_EVT-1:0]   sw_trig;
  logic [1:0]                            err_clr;
  soc_periph_pkg::evt_vec_t              raise;
  soc_periph_pkg::evt_vec_t [1:0]        mask_q;
  soc_periph_pkg::evt_vec_t [1:0]        pend_q;
  soc_periph_pkg::evt_vec_t [1:0]        pend_d;
  logic [1:0]                            ovf;
  logic [1:0]                            err_q;
  logic [1:0]                            dst_ready;
  soc_periph_pkg::evt_msg_t [1:0]        dst_evt;

  assign reg_ofs = apb_req_i.paddr[soc_periph_pkg::REG_OFS_LSB +: 4];
  assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite & ~apb_rsp_o.pslverr;

  // sw trigger is a one-cycle strobe off the write
  assign sw_trig = (wr_en && reg_ofs == soc_periph_pkg::EVT_SW_TRIG) ?
                   apb_req_i.pwdata[soc_periph_pkg::N_SW_EVT-1:0] : '0;
  assign err_clr = (wr_en && reg_ofs == soc_periph_pkg::EVT_ERR) ? apb_req_i.pwdata[1:0] : 2'b00;

  // event vector by id map
  always_comb begin
    raise = '0;
    raise[soc_periph_pkg::EVT_ID_SW_BASE +: soc_periph_pkg::N_SW_EVT] = sw_trig;
    raise[soc_periph_pkg::EVT_ID_GPIO_BASE +: soc_periph_pkg::N_GPIO] = gpio_evt_i;
    raise[soc_periph_pkg::EVT_ID_TIMER] = tmr_evt_i;
  end

  assign dst_ready = {cl_event_ready_i, fc_event_ready_i};

  //////////////////////////////
  // per destination path
  //////////////////////////////
  for (genvar d = 0; d < 2; d++) begin : g_dst
    logic                     sel_vld;
    soc_periph_pkg::evt_id_t  sel_id;
    soc_periph_pkg::evt_vec_t pop_vec;
    logic                     fifo_full;
    logic                     push;

    // scan down so the lowest set bit wins
    always_comb begin
      sel_vld = 1'b0;
      sel_id  = '0;
      for (int i = soc_periph_pkg::N_EVT_ID - 1; i >= 0; i--) begin
        if (pend_q[d][i]) begin
          sel_vld = 1'b1;
          sel_id  = soc_periph_pkg::evt_id_t'(i);
        end
      end
    end

    assign push    = sel_vld & ~fifo_full;
    assign pop_vec = push ? (soc_periph_pkg::evt_vec_t'(1) << sel_id) : '0;
    // full fifo leaves bits pending, a repeat there is lost
    assign ovf[d]    = |(raise & mask_q[d] & pend_q[d] & ~pop_vec);
    assign pend_d[d] = (pend_q[d] & ~pop_vec) | (raise & mask_q[d]);

    event_fifo event_fifo_i (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .push_i    (push),
      .push_id_i (sel_id),
      .full_o    (fifo_full),
      .evt_o     (dst_evt[d]),
      .ready_i   (dst_ready[d])
    );
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mask_q <= '0;
      pend_q <= '0;
      err_q  <= 2'b00;
    end else begin
      pend_q <= pend_d;
      // new overflow beats a same-cycle clear
      err_q  <= (err_q & ~err_clr) | ovf;
      if (wr_en && reg_ofs == soc_periph_pkg::EVT_FC_MASK) mask_q[0] <= apb_req_i.pwdata;
      if (wr_en && reg_ofs == soc_periph_pkg::EVT_CL_MASK) mask_q[1] <= apb_req_i.pwdata;
    end
  end

  always_comb begin
    apb_rsp_o.prdata  = '0;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b0;
    case (reg_ofs)
      soc_periph_pkg::EVT_FC_MASK: apb_rsp_o.prdata = mask_q[0];
      soc_periph_pkg::EVT_CL_MASK: apb_rsp_o.prdata = mask_q[1];
      soc_periph_pkg::EVT_SW_TRIG: apb_rsp_o.prdata = '0;
      soc_periph_pkg::EVT_ERR:     apb_rsp_o.prdata = soc_periph_pkg::apb_data_t'(err_q);
      default:                     apb_rsp_o.pslverr = 1'b1;
    endcase
  end

  assign fc_event_o = dst_evt[0];
  assign cl_event_o = dst_evt[1];

endmodule

/* src/soc_periph_pkg.sv */
//////////////////////////////
// shared widths, address map, event ids and bus structs
// apb has no wait states, pready is always high
// event fifo depth must be a power of two
//////////////////////////////

package soc_periph_pkg;

  // bus and peripheral sizes
  localparam int APB_ADDR_W     = 32;
  localparam int APB_DATA_W     = 32;
  localparam int N_GPIO         = 16;
  localparam int EVNT_W         = 8;
  localparam int EVT_FIFO_DEPTH = 4;
  localparam int EVT_PTR_W      = $clog2(EVT_FIFO_DEPTH);
  localparam int N_EVT_ID       = 32;
  localparam int N_SW_EVT       = 8;

  //////////////////////////////
  // address map
  //////////////////////////////
  // paddr[13:12] picks the slave, code 3 unmapped
  localparam int         SLV_SEL_LSB = 12;
  localparam logic [1:0] SLV_GPIO    = 2'd0;
  localparam logic [1:0] SLV_TIMER   = 2'd1;
  localparam logic [1:0] SLV_EVT     = 2'd2;

  // word offset inside a slave, paddr[5:2]
  localparam int         REG_OFS_LSB = 2;

  localparam logic [3:0] GPIO_DIR    = 4'd0;
  localparam logic [3:0] GPIO_OUT    = 4'd1;
  localparam logic [3:0] GPIO_IN     = 4'd2;
  localparam logic [3:0] GPIO_INT_EN = 4'd3;

  localparam logic [3:0] TMR_CFG     = 4'd0;
  localparam logic [3:0] TMR_CNT     = 4'd1;
  localparam logic [3:0] TMR_CMP     = 4'd2;

  localparam logic [3:0] EVT_FC_MASK = 4'd0;
  localparam logic [3:0] EVT_CL_MASK = 4'd1;
  localparam logic [3:0] EVT_SW_TRIG = 4'd2;
  localparam logic [3:0] EVT_ERR     = 4'd3;

  // event id map
  localparam int EVT_ID_SW_BASE   = 0;
  localparam int EVT_ID_GPIO_BASE = 8;
  localparam int EVT_ID_TIMER     = 24;

  //////////////////////////////
  // types
  //////////////////////////////
  typedef logic [APB_DATA_W-1:0] apb_data_t;
  typedef logic [N_GPIO-1:0]     gpio_t;
  typedef logic [EVNT_W-1:0]     evt_id_t;
  typedef logic [N_EVT_ID-1:0]   evt_vec_t;

  typedef struct packed {
    logic [APB_ADDR_W-1:0] paddr;
    apb_data_t             pwdata;
    logic                  pwrite;
    logic                  psel;
    logic                  penable;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic    valid;
    evt_id_t id;
  } evt_msg_t;

endpackage

/* src/soc_periph_top.sv */
//////////////////////////////
// peripheral side of the soc control domain
// single clock, slow_clk_i is sampled, not used as a clock
//////////////////////////////

`timescale 1ns/100ps

module soc_periph_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     slow_clk_i,
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  input  soc_periph_pkg::gpio_t    gpio_in_i,
  output soc_periph_pkg::gpio_t    gpio_out_o,
  output soc_periph_pkg::gpio_t    gpio_oe_o,
  output soc_periph_pkg::evt_msg_t fc_event_o,
  output soc_periph_pkg::evt_msg_t cl_event_o,
  input  logic                     fc_event_ready_i,
  input  logic                     cl_event_ready_i
);

  // per slave bus
  soc_periph_pkg::apb_req_t gpio_req;
  soc_periph_pkg::apb_req_t tmr_req;
  soc_periph_pkg::apb_req_t evt_req;
  soc_periph_pkg::apb_rsp_t gpio_rsp;
  soc_periph_pkg::apb_rsp_t tmr_rsp;
  soc_periph_pkg::apb_rsp_t evt_rsp;

  // event pulses into the generator
  soc_periph_pkg::gpio_t gpio_evt;
  logic                  tmr_evt;

  //////////////////////////////
  // apb decode
  //////////////////////////////
  apb_periph_decode apb_periph_decode_i (
    .apb_req_i  (apb_req_i),
    .gpio_req_o (gpio_req),
    .tmr_req_o  (tmr_req),
    .evt_req_o  (evt_req),
    .gpio_rsp_i (gpio_rsp),
    .tmr_rsp_i  (tmr_rsp),
    .evt_rsp_i  (evt_rsp),
    .apb_rsp_o  (apb_rsp_o)
  );

  //////////////////////////////
  // peripherals
  //////////////////////////////
  apb_gpio apb_gpio_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .apb_req_i  (gpio_req),
    .apb_rsp_o  (gpio_rsp),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o),
    .gpio_evt_o (gpio_evt)
  );

  apb_timer apb_timer_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .slow_clk_i (slow_clk_i),
    .apb_req_i  (tmr_req),
    .apb_rsp_o  (tmr_rsp),
    .tmr_evt_o  (tmr_evt)
  );

  soc_event_gen soc_event_gen_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .apb_req_i        (evt_req),
    .apb_rsp_o        (evt_rsp),
    .gpio_evt_i       (gpio_evt),
    .tmr_evt_i        (tmr_evt),
    .fc_event_o       (fc_event_o),
    .cl_event_o       (cl_event_o),
    .fc_event_ready_i (fc_event_ready_i),
    .cl_event_ready_i (cl_event_ready_i)
  );

endmodule

/* tb/tb_soc_periph.sv */
//////////////////////////////
// random testbench for soc_periph_top against a model
// apb accesses take 3 cycles including the idle cycle
// model tracks raised ids per destination, not their order
//////////////////////////////

`timescale 1ns/100ps

module tb_soc_periph;

  localparam int N_OPS   = 400;
  localparam int TIMEOUT = 20 * N_OPS + 2000;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     slow_clk_i;
  soc_periph_pkg::apb_req_t apb_req;
  soc_periph_pkg::apb_rsp_t apb_rsp;
  soc_periph_pkg::gpio_t    gpio_in;
  soc_periph_pkg::gpio_t    gpio_out;
  soc_periph_pkg::gpio_t    gpio_oe;
  soc_periph_pkg::evt_msg_t fc_event;
  soc_periph_pkg::evt_msg_t cl_event;
  logic                     fc_ready;
  logic                     cl_ready;

  // model state and register shadows
  integer                    seed;
  integer                    errors;
  integer                    checks;
  integer                    cycles;
  integer                    ready_mode;
  soc_periph_pkg::gpio_t     dir_sh;
  soc_periph_pkg::gpio_t     out_sh;
  soc_periph_pkg::gpio_t     inten_sh;
  soc_periph_pkg::apb_data_t cmp_sh;
  soc_periph_pkg::evt_vec_t  mask_sh [2];
  soc_periph_pkg::evt_vec_t  outst [2];
  soc_periph_pkg::evt_id_t   cl_log [$];

  soc_periph_top soc_periph_top_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .slow_clk_i       (slow_clk_i),
    .apb_req_i        (apb_req),
    .apb_rsp_o        (apb_rsp),
    .gpio_in_i        (gpio_in),
    .gpio_out_o       (gpio_out),
    .gpio_oe_o        (gpio_oe),
    .fc_event_o       (fc_event),
    .cl_event_o       (cl_event),
    .fc_event_ready_i (fc_ready),
    .cl_event_ready_i (cl_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // run limit
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles, run did not finish", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////
  // compare tasks
  //////////////////////////////
  task automatic check_rdata(input string name, input soc_periph_pkg::apb_data_t got,
                             input soc_periph_pkg::apb_data_t exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_gpio(input string name, input soc_periph_pkg::gpio_t got,
                            input soc_periph_pkg::gpio_t exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_evt(input string name, input soc_periph_pkg::evt_id_t got,
                           input soc_periph_pkg::evt_id_t exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  //////////////////////////////
  // event monitor
  //////////////////////////////
  // a delivered id must be outstanding in the model
  task automatic take_event(input int d, input soc_periph_pkg::evt_id_t id);
    checks = checks + 1;
    if (id >= soc_periph_pkg::N_EVT_ID || !outst[d][id]) begin
      errors = errors + 1;
      $display("unexpected event id %h delivered on destination %0d", id, d);
    end else begin
      outst[d][id] = 1'b0;
    end
    if (d == 1) cl_log.push_back(id);
  endtask

  // ready driven and transfer seen in one place, valid is settled here
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      case (ready_mode)
        1: begin
          fc_ready = $random(seed) & 1;
          cl_ready = $random(seed) & 1;
        end
        2: begin
          fc_ready = 1'b1;
          cl_ready = 1'b0;
        end
        default: begin
          fc_ready = 1'b1;
          cl_ready = 1'b1;
        end
      endcase
      if (fc_event.valid && fc_ready) take_event(0, fc_event.id);
      if (cl_event.valid && cl_ready) take_event(1, cl_event.id);
    end
  end

  //////////////////////////////
  // apb driver
  //////////////////////////////
  task automatic apb_access(input logic [1:0] slv, input logic [3:0] ofs, input logic wr,
                            input soc_periph_pkg::apb_data_t wdata,
                            output soc_periph_pkg::apb_data_t rdata, output logic slverr);
    // setup cycle
    @(negedge clk_i);
    apb_req.paddr   = {18'd0, slv, 6'd0, ofs, 2'd0};
    apb_req.pwdata  = wdata;
    apb_req.pwrite  = wr;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    // access cycle, response sampled mid-phase
    @(negedge clk_i);
    apb_req.penable = 1'b1;
    #10;
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    // no wait states, every access cycle completes
    check_err("pready", apb_rsp.pready, 1'b1);
    @(negedge clk_i);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input logic [1:0] slv, input logic [3:0] ofs,
                           input soc_periph_pkg::apb_data_t wdata);
    soc_periph_pkg::apb_data_t rd;
    logic                      err;
    apb_access(slv, ofs, 1'b1, wdata, rd, err);
  endtask

  task automatic read_check(input logic [1:0] slv, input logic [3:0] ofs,
                            input soc_periph_pkg::apb_data_t exp, input string name);
    soc_periph_pkg::apb_data_t rd;
    logic                      err;
    apb_access(slv, ofs, 1'b0, '0, rd, err);
    check_rdata(name, rd, exp);
    check_err("pslverr", err, 1'b0);
  endtask

  // software trigger, model marks ids on masked destinations
  task automatic sw_trigger(input logic [7:0] ids);
    outst[0] = outst[0] | (soc_periph_pkg::evt_vec_t'(ids) & mask_sh[0]);
    outst[1] = outst[1] | (soc_periph_pkg::evt_vec_t'(ids) & mask_sh[1]);
    apb_write(soc_periph_pkg::SLV_EVT, soc_periph_pkg::EVT_SW_TRIG, {24'd0, ids});
  endtask

  task automatic write_mask(input int d, input soc_periph_pkg::evt_vec_t m);
    mask_sh[d] = m;
    apb_write(soc_periph_pkg::SLV_EVT, (d == 0) ? soc_periph_pkg::EVT_FC_MASK :
              soc_periph_pkg::EVT_CL_MASK, m);
  endtask

  task automatic wait_drained();
    integer n;
    n = 0;
    while ((outst[0] | outst[1]) != '0 && n < 300) begin
      @(negedge clk_i);
      n = n + 1;
    end
    if ((outst[0] | outst[1]) != '0) begin
      errors = errors + 1;
      $display("events never delivered, fc %h cl %h", outst[0], outst[1]);
    end
  endtask

  // full readback of every writable register
  task automatic verify_regs();
    read_check(soc_periph_pkg::SLV_GPIO, soc_periph_pkg::GPIO_DIR, {16'd0, dir_sh}, "GPIO_DIR");
    read_check(soc_periph_pkg::SLV_GPIO, soc_periph_pkg::GPIO_OUT, {16'd0, out_sh}, "GPIO_OUT");
    read_check(soc_periph_pkg::SLV_GPIO, soc_periph_pkg::GPIO_INT_EN, {16'd0, inten_sh},
               "GPIO_INT_EN");
    read_check(soc_periph_pkg::SLV_EVT, soc_periph_pkg::EVT_FC_MASK, mask_sh[0], "EVT_FC_MASK");
    read_check(soc_periph_pkg::SLV_EVT, soc_periph_pkg::EVT_CL_MASK, mask_sh[1], "EVT_CL_MASK");
    read_check(soc_periph_pkg::SLV_TIMER, soc_periph_pkg::TMR_CMP, cmp_sh, "TMR_CMP");
    read_check(soc_periph_pkg::SLV_EVT, soc_periph_pkg::EVT_ERR, '0, "EVT_ERR");
    check_gpio("gpio_out_o", gpio_out, out_sh);
    check_gpio("gpio_oe_o", gpio_oe, dir_sh);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    soc_periph_pkg::apb_data_t d;
    soc_periph_pkg::apb_data_t rd;
    soc_periph_pkg::gpio_t     v;
    logic                      err;
    logic [7:0]                ids;
    integer                    k;
    integer                    edges;
    integer                    hold;

    seed       = 32'hf1f3_a7fa;
    errors     = 0;
    checks     = 0;
    cycles     = 0;
    ready_mode = 0;
    rst_n_i    = 1'b0;
    slow_clk_i = 1'b0;
    apb_req    = '0;
    gpio_in    = '0;
    fc_ready   = 1'b1;
    cl_ready   = 1'b1;
    dir_sh     = '0;
    out_sh     = '0;
    inten_sh   = '0;
    cmp_sh     = '0;
    mask_sh[0] = '0;
    mask_sh[1] = '0;
    outst[0]   = '0;
    outst[1]   = '0;
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;

    // reset values, shadows are all zero here
    verify_regs();

    // 1. random register writes and readback
    for (k = 0; k < 40; k++) begin
      d = $random(seed);
      case (($random(seed) & 32'h7fff_ffff) % 6)
        0: begin
          dir_sh = d[15:0];
          apb_write(soc_periph_pkg::SLV_GPIO, soc_periph_pkg::GPIO_DIR, d);
        end
        1: begin
          out_sh = d[15:0];
          apb_write(soc_periph_pkg::SLV_GPIO, soc_periph_pkg::GPIO_OUT, d);
        end
        2: begin
          inten_sh = d[15:0];
          apb_write(soc_periph_pkg::SLV_GPIO, soc_periph_pkg::GPIO_INT_EN, d);
        end
        3: write_mask(0, d);
        4: write_mask(1, d);
        default: begin
          cmp_sh = d;
          apb_write(soc_periph_pkg::SLV_TIMER, soc_periph_pkg::TMR_CMP, d);
        end
      endcase
    end
    verify_regs();

    // 2. unmapped slave and offsets
    apb_access(2'd3, 4'd0, 1'b0, '0, rd, err);
    check_rdata("prdata", rd, '0);
    check_err("pslverr", err, 1'b1);
    apb_access(2'd3, 4'd1, 1'b1, $random(seed), rd, err);
    check_err("pslverr", err, 1'b1);
    apb_access(soc_periph_pkg::SLV_GPIO, 4'(($random(seed) & 7) + 4), 1'b1, $random(seed),
               rd, err);
    check_err("pslverr", err, 1'b1);
    apb_access(soc_periph_pkg::SLV_TIMER, 4'(($random(seed) & 7) + 3), 1'b1, $random(seed),
               rd, err);
    check_err("pslverr", err, 1'b1);
    apb_access(soc_periph_pkg::SLV_EVT, 4'(($random(seed) & 7) + 4), 1'b0, '0, rd, err);
    check_rdata("prdata", rd, '0);
    check_err("pslverr", err, 1'b1);
    verify_regs();

    // 3. pad sync and gpio edge events
    inten_sh = 16'($random(seed));
    apb_write(soc_periph_pkg::SLV_GPIO, soc_periph_pkg::GPIO_INT_EN, {16'd0, inten_sh});
    write_mask(0, $random(seed));
    write_mask(1, $random(seed));
    for (k = 0; k < 8; k++) begin
      @(negedge clk_i);
      gpio_in = '0;
      repeat (4) @(negedge clk_i);
      v = 16'($random(seed));
      // rising from zero on enabled pins only
      outst[0] = outst[0] | ((soc_periph_pkg::evt_vec_t'(v & inten_sh) << 8) & mask_sh[0]);
      outst[1] = outst[1] | ((soc_periph_pkg::evt_vec_t'(v & inten_sh) << 8) & mask_sh[1]);
      gpio_in = v;
      repeat (3) @(negedge clk_i);
      apb_access(soc_periph_pkg::SLV_GPIO, soc_periph_pkg::GPIO_IN, 1'b0, '0, rd, err);
      check_gpio("GPIO_IN", rd[15:0], v);
      wait_drained();
    end

    // 4. software triggers under random back-pressure
    ready_mode = 1;
    write_mask(0, $random(seed));
    write_mask(1, $random(seed));
    for (k = 0; k < 30; k++) begin
      // skip ids still in flight, a repeat would merge
      ids = 8'($random(seed)) & ~(outst[0][7:0] | outst[1][7:0]);
      sw_trigger(ids);
      repeat ($random(seed) & 3) @(negedge clk_i);
    end
    ready_mode = 0;
    wait_drained();
    read_check(soc_periph_pkg::SLV_EVT, soc_periph_pkg::EVT_ERR, '0, "EVT_ERR");

    // 5. cluster overflow with ready held low
    write_mask(0, '0);
    write_mask(1, 32'h0000_00ff);
    ready_mode = 2;
    @(negedge clk_i);
    cl_log.delete();
    for (k = 0; k < 5; k++) sw_trigger(8'(1 << k));
    // id 4 still pending behind a full fifo
    sw_trigger(8'h10);
    read_check(soc_periph_pkg::SLV_EVT, soc_periph_pkg::EVT_ERR, 32'h2, "EVT_ERR");
    apb_write(soc_periph_pkg::SLV_EVT, soc_periph_pkg::EVT_ERR, 32'h2);
    read_check(soc_periph_pkg::SLV_EVT, soc_periph_pkg::EVT_ERR, '0, "EVT_ERR");
    ready_mode = 0;
    wait_drained();
    if (cl_log.size() != 5) begin
      errors = errors + 1;
      $display("cluster stream gave %0d events instead of 5", cl_log.size());
    end else begin
      for (k = 0; k < 5; k++) check_evt("cl_event_o.id", cl_log[k], 8'(k));
    end

    // 6. timer counting random slow clock edges
    write_mask(0, $random(seed));
    write_mask(1, $random(seed));
    cmp_sh = 32'(1 + ($random(seed) & 3));
    apb_write(soc_periph_pkg::SLV_TIMER, soc_periph_pkg::TMR_CMP, cmp_sh);
    apb_write(soc_periph_pkg::SLV_TIMER, soc_periph_pkg::TMR_CNT, '0);
    apb_write(soc_periph_pkg::SLV_TIMER, soc_periph_pkg::TMR_CFG, 32'h1);
    edges = 0;
    for (k = 0; k < 40; k++) begin
      hold = ($random(seed) & 3) + 3;
      @(negedge clk_i);
      if (!slow_clk_i) begin
        edges = edges + 1;
        // wrap raises id 24
        if (edges % (cmp_sh + 1) == 0) begin
          outst[0][soc_periph_pkg::EVT_ID_TIMER] |= mask_sh[0][soc_periph_pkg::EVT_ID_TIMER];
          outst[1][soc_periph_pkg::EVT_ID_TIMER] |= mask_sh[1][soc_periph_pkg::EVT_ID_TIMER];
        end
      end
      slow_clk_i = ~slow_clk_i;
      repeat (hold) @(negedge clk_i);
    end
    slow_clk_i = 1'b0;
    repeat (4) @(negedge clk_i);
    read_check(soc_periph_pkg::SLV_TIMER, soc_periph_pkg::TMR_CNT,
               32'(edges % (cmp_sh + 1)), "TMR_CNT");
    apb_write(soc_periph_pkg::SLV_TIMER, soc_periph_pkg::TMR_CFG, '0);
    wait_drained();
    read_check(soc_periph_pkg::SLV_EVT, soc_periph_pkg::EVT_ERR, '0, "EVT_ERR");

    repeat (4) @(negedge clk_i);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
